// File: mm_consts.svh
`ifndef MM_CONSTS_SVH
`define MM_CONSTS_SVH

// element and address widths
`define MM_DWIDTH 8
`define MM_AWIDTH 7

// rows per memory
`define MM_MEM_SIZE 128

// array edge, also matrix size
`define MM_SIZE 4

// operand in to accumulator, in cycles
`define MM_MAC_CYCLES 3

// run count at which done is set
`define MM_RUN_CYCLES 26

// host read of C, request to rd_data
`define MM_RD_LATENCY 3

// row r is latched at this count plus r
`define MM_LATCH_BASE 13

`endif

// File: mm_data_pkg.sv
`default_nettype none
`include "mm_consts.svh"

package mm_data_pkg;

  // one matrix element, two's complement
  typedef logic signed [`MM_DWIDTH-1:0] elem_t;

  // full product before saturation
  typedef logic signed [2*`MM_DWIDTH-1:0] prod_t;

  // one memory row, element 0 in the low byte
  typedef elem_t [`MM_SIZE-1:0] row_t;

  // saturation bounds of elem_t, widened
  localparam prod_t ELEM_MAX = prod_t'((2 ** (`MM_DWIDTH - 1)) - 1);
  localparam prod_t ELEM_MIN = prod_t'(-(2 ** (`MM_DWIDTH - 1)));

  // full signed multiply, then clamp into the element range
  function automatic elem_t sat_mul(input elem_t a, input elem_t b);
    prod_t p;
    p = prod_t'(a) * prod_t'(b);
    if (p > ELEM_MAX) begin
      return elem_t'(ELEM_MAX);
    end else if (p < ELEM_MIN) begin
      return elem_t'(ELEM_MIN);
    end
    return elem_t'(p);
  endfunction

endpackage

`default_nettype wire

// File: mm_ctrl_pkg.sv
`default_nettype none
`include "mm_consts.svh"

package mm_ctrl_pkg;

  import mm_data_pkg::*;

  // row address into any of the three memories
  typedef logic [`MM_AWIDTH-1:0] addr_t;

  // one host cycle on the memory port
  // at most one of wr_a, wr_b, rd_c per cycle
  typedef struct packed {
    logic  wr_a;
    logic  wr_b;
    logic  rd_c;
    addr_t addr;
    row_t  wdata;
  } host_req_t;

  // strobes from the sequencer
  // clear: zero the array before a run
  // feed: A/B read data is valid this cycle
  // latch_row: one hot, capture row r of the accumulators
  typedef struct packed {
    logic                clear;
    logic                feed;
    logic [`MM_SIZE-1:0] latch_row;
  } seq_ctrl_t;

endpackage

`default_nettype wire

// File: matrix_ram.sv
`default_nettype none
`include "mm_consts.svh"

module matrix_ram
  import mm_data_pkg::*;
  import mm_ctrl_pkg::*;
(
  input  wire        clk_mem,
  input  wire addr_t addr,
  input  wire row_t  wdata,
  input  wire        we,
  output row_t       rdata
);

  row_t mem [`MM_MEM_SIZE];

  // read before write on the same address
  always_ff @(posedge clk_mem) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];
  end

  // a write to an unknown row would corrupt the whole array in simulation
  a_we_addr_known : assert property (@(posedge clk_mem) we |-> !$isunknown(addr));

endmodule

`default_nettype wire

// File: mm_sequencer.sv
`default_nettype none
`include "mm_consts.svh"

module mm_sequencer
  import mm_ctrl_pkg::*;
(
  input  wire       clk_mem,
  input  wire       reset,
  input  wire       start,
  output addr_t     a_addr,
  output addr_t     b_addr,
  output seq_ctrl_t ctrl,
  output logic      done
);

  localparam int unsigned CNT_W = $clog2(`MM_RUN_CYCLES + 1);
  // count whose strobe lines up with the first valid RAM row
  // address reg, then RAM read
  localparam int unsigned FEED_FIRST = 2;

  logic [CNT_W-1:0] cnt;
  addr_t            feed_addr;

  // run counter, held at zero while start is low
  // parks at the final count once done is set
  always_ff @(posedge clk_mem) begin
    if (reset || !start) begin
      cnt  <= '0;
      done <= 1'b0;
    end else if (cnt == CNT_W'(`MM_RUN_CYCLES)) begin
      done <= 1'b1;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // registered decode of the count
  always_ff @(posedge clk_mem) begin
    if (reset || !start) begin
      feed_addr <= addr_t'(`MM_MEM_SIZE - 1);
      ctrl      <= '0;
    end else begin
      // A column k and B row k share address k
      if ((cnt != '0) && (cnt <= CNT_W'(`MM_SIZE))) begin
        feed_addr <= addr_t'(cnt - 1'b1);
      end else begin
        feed_addr <= addr_t'(`MM_MEM_SIZE - 1);
      end
      ctrl.clear <= (cnt == '0);
      ctrl.feed  <= (cnt >= CNT_W'(FEED_FIRST)) &&
                    (cnt < CNT_W'(FEED_FIRST + `MM_SIZE));
      // rows finish one cycle apart, top row first
      for (int r = 0; r < `MM_SIZE; r++) begin
        ctrl.latch_row[r] <= (cnt == CNT_W'(`MM_LATCH_BASE + r));
      end
    end
  end

  // both memories step through the same rows
  assign a_addr = feed_addr;
  assign b_addr = feed_addr;

  // done only after a full run with start held from count 0
  a_done_after_run : assert property (
    @(posedge clk_mem) disable iff (reset)
    $rose(done) |-> $past(start) && $past(start, `MM_RUN_CYCLES + 1)
  );

endmodule

`default_nettype wire

// File: mac_pe.sv
`default_nettype none
`include "mm_consts.svh"

module mac_pe
  import mm_data_pkg::*;
(
  input  wire        clk_mem,
  input  wire        reset,
  input  wire        clear,
  input  wire elem_t in_a,
  input  wire elem_t in_b,
  output elem_t      out_a,
  output elem_t      out_b,
  output elem_t      acc
);

  elem_t prod_q;

  // stage 1: operand regs, also the hop to the next cell
  // stage 2: saturated product
  // stage 3: wrapping accumulate
  always_ff @(posedge clk_mem) begin
    if (reset || clear) begin
      out_a  <= '0;
      out_b  <= '0;
      prod_q <= '0;
      acc    <= '0;
    end else begin
      out_a  <= in_a;
      out_b  <= in_b;
      prod_q <= sat_mul(out_a, out_b);
      // 8-bit add, overflow wraps
      acc    <= acc + prod_q;
    end
  end

  // zero operands for a full pipeline depth leave the sum alone
  // relies on the top zeroing idle read data
  a_idle_acc_stable : assert property (
    @(posedge clk_mem) disable iff (reset || clear)
    (in_a == '0) [*`MM_MAC_CYCLES] |=> $stable(acc)
  );

endmodule

`default_nettype wire

// File: systolic_array.sv
`default_nettype none
`include "mm_consts.svh"

module systolic_array
  import mm_data_pkg::*;
(
  input  wire                       clk_mem,
  input  wire                       reset,
  input  wire                       clear,
  input  wire row_t                 a_row,
  input  wire row_t                 b_row,
  output wire row_t [`MM_SIZE-1:0]  acc
);

  // a moving east, indexed [row][col], col MM_SIZE leaves the array
  wire elem_t [`MM_SIZE-1:0][`MM_SIZE:0] a_h;
  // b moving south, indexed [col][row], row MM_SIZE leaves the array
  wire elem_t [`MM_SIZE-1:0][`MM_SIZE:0] b_v;

  // input skew, element i late by i cycles
  // so A[i][k] and B[k][j] meet in cell (i,j) on the same edge
  for (genvar i = 0; i < `MM_SIZE; i++) begin : g_skew
    if (i == 0) begin : g_lead
      assign a_h[i][0] = a_row[i];
      assign b_v[i][0] = b_row[i];
    end else begin : g_lag
      elem_t [i-1:0] a_sr;
      elem_t [i-1:0] b_sr;

      always_ff @(posedge clk_mem) begin
        if (reset || clear) begin
          a_sr <= '0;
          b_sr <= '0;
        end else begin
          a_sr[0] <= a_row[i];
          b_sr[0] <= b_row[i];
          for (int d = 1; d < i; d++) begin
            a_sr[d] <= a_sr[d-1];
            b_sr[d] <= b_sr[d-1];
          end
        end
      end

      assign a_h[i][0] = a_sr[i-1];
      assign b_v[i][0] = b_sr[i-1];
    end
  end

  // 4x4 grid, cell (i,j) ends up holding C[i][j]
  for (genvar i = 0; i < `MM_SIZE; i++) begin : g_row
    for (genvar j = 0; j < `MM_SIZE; j++) begin : g_col
      mac_pe i_pe (
        .clk_mem (clk_mem),
        .reset   (reset),
        .clear   (clear),
        .in_a    (a_h[i][j]),
        .in_b    (b_v[j][i]),
        .out_a   (a_h[i][j+1]),
        .out_b   (b_v[j][i+1]),
        .acc     (acc[i][j])
      );
    end
  end

endmodule

`default_nettype wire

// File: result_drain.sv
`default_nettype none
`include "mm_consts.svh"

module result_drain
  import mm_data_pkg::*;
  import mm_ctrl_pkg::*;
(
  input  wire                      clk_mem,
  input  wire                      reset,
  input  wire [`MM_SIZE-1:0]       latch_row,
  input  wire row_t [`MM_SIZE-1:0] acc,
  output logic                     c_wr,
  output addr_t                    c_addr,
  output row_t                     c_row
);

  // one shift register per array row, element 0 leaves first
  row_t [`MM_SIZE-1:0]         row_sr;
  logic [$clog2(`MM_SIZE)-1:0] col_idx;

  // rows load one by one and wait, then all shift together while writing
  always_ff @(posedge clk_mem) begin
    for (int r = 0; r < `MM_SIZE; r++) begin
      if (latch_row[r]) begin
        row_sr[r] <= acc[r];
      end else if (c_wr) begin
        row_sr[r] <= {elem_t'(0), row_sr[r][`MM_SIZE-1:1]};
      end
    end
  end

  // four writes right after the bottom row is latched
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      c_wr    <= 1'b0;
      col_idx <= '0;
    end else if (latch_row[`MM_SIZE-1]) begin
      c_wr    <= 1'b1;
      col_idx <= '0;
    end else if (c_wr) begin
      col_idx <= col_idx + 1'b1;
      if (col_idx == ($bits(col_idx))'(`MM_SIZE - 1)) begin
        c_wr <= 1'b0;
      end
    end
  end

  assign c_addr = addr_t'(col_idx);

  // head of every row forms column col_idx of C
  always_comb begin
    for (int r = 0; r < `MM_SIZE; r++) begin
      c_row[r] = row_sr[r][0];
    end
  end

  a_latch_onehot : assert property (
    @(posedge clk_mem) disable iff (reset) $onehot0(latch_row)
  );

endmodule

`default_nettype wire

// File: matmul_top.sv
`default_nettype none
`include "mm_consts.svh"

module matmul_top
  import mm_data_pkg::*;
  import mm_ctrl_pkg::*;
(
  input  wire            clk_mem,
  input  wire            reset,
  input  wire            start,
  input  wire host_req_t host,
  output row_t           rd_data,
  output logic           done
);

  host_req_t           host_q;
  seq_ctrl_t           ctrl;
  addr_t               a_addr;
  addr_t               b_addr;
  addr_t               c_addr;
  addr_t               a_addr_mux;
  addr_t               b_addr_mux;
  addr_t               c_addr_mux;
  row_t                a_rdata;
  row_t                b_rdata;
  row_t                c_rdata;
  row_t                a_row;
  row_t                b_row;
  row_t                c_row;
  row_t [`MM_SIZE-1:0] acc;
  logic                c_wr;
  logic                rd_dly;

  // host request, one cycle
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      host_q <= '0;
    end else begin
      host_q <= host;
    end
  end

  // host owns A/B only on its write cycle, C whenever the drain is idle
  assign a_addr_mux = host_q.wr_a ? host_q.addr : a_addr;
  assign b_addr_mux = host_q.wr_b ? host_q.addr : b_addr;
  assign c_addr_mux = c_wr ? c_addr : host_q.addr;

  matrix_ram mem_a (
    .clk_mem (clk_mem),
    .addr    (a_addr_mux),
    .wdata   (host_q.wdata),
    .we      (host_q.wr_a),
    .rdata   (a_rdata)
  );

  matrix_ram mem_b (
    .clk_mem (clk_mem),
    .addr    (b_addr_mux),
    .wdata   (host_q.wdata),
    .we      (host_q.wr_b),
    .rdata   (b_rdata)
  );

  matrix_ram mem_c (
    .clk_mem (clk_mem),
    .addr    (c_addr_mux),
    .wdata   (c_row),
    .we      (c_wr),
    .rdata   (c_rdata)
  );

  // array operands, zero outside the feed window
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      a_row <= '0;
      b_row <= '0;
    end else begin
      a_row <= ctrl.feed ? a_rdata : '0;
      b_row <= ctrl.feed ? b_rdata : '0;
    end
  end

  // C read: request reg, RAM, output reg
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      rd_dly  <= 1'b0;
      rd_data <= '0;
    end else begin
      rd_dly <= host_q.rd_c;
      if (rd_dly) begin
        rd_data <= c_rdata;
      end
    end
  end

  mm_sequencer i_sequencer (
    .clk_mem (clk_mem),
    .reset   (reset),
    .start   (start),
    .a_addr  (a_addr),
    .b_addr  (b_addr),
    .ctrl    (ctrl),
    .done    (done)
  );

  systolic_array i_array (
    .clk_mem (clk_mem),
    .reset   (reset),
    .clear   (ctrl.clear),
    .a_row   (a_row),
    .b_row   (b_row),
    .acc     (acc)
  );

  result_drain i_drain (
    .clk_mem   (clk_mem),
    .reset     (reset),
    .latch_row (ctrl.latch_row),
    .acc       (acc),
    .c_wr      (c_wr),
    .c_addr    (c_addr),
    .c_row     (c_row)
  );

  // memories belong to the sequencer and drain during a run
  a_no_host_in_run : assert property (
    @(posedge clk_mem) disable iff (reset)
    start |-> !(host.wr_a || host.wr_b || host.rd_c)
  );

endmodule

`default_nettype wire

// File: tb_matmul.sv
`default_nettype none
`include "mm_consts.svh"

module tb_matmul
  import mm_data_pkg::*;
  import mm_ctrl_pkg::*;
();

  localparam int CLK_PERIOD   = 20;
  localparam int NUM_CASES    = 3;
  localparam int NUM_RANDOM   = 5;
  localparam int CASE_WORDS   = 3 * `MM_SIZE;
  localparam int WATCH_CYCLES = (NUM_CASES + NUM_RANDOM) * 200;
  localparam int DONE_LIMIT   = 2 * `MM_RUN_CYCLES;
  localparam int HOLD_CYCLES  = 10;
  localparam int ELEM_MAX     = 127;
  localparam int ELEM_MIN     = -128;
  localparam logic [31:0] RAND_SEED = 32'h85c6_e48d;

  logic      clk_mem;
  logic      reset;
  logic      start;
  host_req_t host;
  row_t      rd_data;
  logic      done;

  // golden words, per case A columns, B rows, expected C columns
  logic [31:0] golden [NUM_CASES*CASE_WORDS];
  row_t        a_cols [`MM_SIZE];
  row_t        b_rows [`MM_SIZE];
  row_t        c_exp  [`MM_SIZE];
  int          errors;
  int          checks;

  matmul_top i_matmul_top (
    .clk_mem (clk_mem),
    .reset   (reset),
    .start   (start),
    .host    (host),
    .rd_data (rd_data),
    .done    (done)
  );

  initial begin
    clk_mem = 1'b0;
    forever #(CLK_PERIOD/2) clk_mem = ~clk_mem;
  end

  // ends a stuck run
  initial begin
    #(WATCH_CYCLES * CLK_PERIOD);
    $display("Timeout after %0d cycles, the run did not finish", WATCH_CYCLES);
    $display("FAIL: see errors above");
    $finish;
  end

  task automatic check_row(input int col, input row_t exp, input row_t got);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("Error at %0t: rd_data (C column %0d) expected %h observed %h",
               $time, col, exp, got);
    end
  endtask

  task automatic check_done(input logic exp);
    checks++;
    assert (done == exp) else begin
      errors++;
      $display("Error at %0t: done expected %b observed %b", $time, exp, done);
    end
  endtask

  // one host write cycle into A or B
  task automatic write_row(input logic to_a, input int addr, input row_t data);
    host_req_t req;
    req       = '0;
    req.wr_a  = to_a;
    req.wr_b  = !to_a;
    req.addr  = addr_t'(addr);
    req.wdata = data;
    @(posedge clk_mem);
    host <= req;
  endtask

  task automatic load_matrices();
    for (int k = 0; k < `MM_SIZE; k++) begin
      write_row(1'b1, k, a_cols[k]);
      write_row(1'b0, k, b_rows[k]);
    end
    @(posedge clk_mem);
    host <= '0;
    // let the last write land before start
    repeat (2) @(posedge clk_mem);
  endtask

  // hold start until done, then hold a while longer and drop it
  task automatic run_multiply();
    int waited;
    waited = 0;
    @(posedge clk_mem);
    start <= 1'b1;
    @(negedge clk_mem);
    while (!done && waited < DONE_LIMIT) begin
      @(negedge clk_mem);
      waited++;
    end
    checks++;
    assert (done) else begin
      errors++;
      $display("done did not rise within %0d cycles of start", DONE_LIMIT);
    end
    // done is a level while start stays high
    repeat (HOLD_CYCLES) begin
      @(negedge clk_mem);
      check_done(1'b1);
    end
    @(posedge clk_mem);
    start <= 1'b0;
    // first edge after start falls clears done
    @(posedge clk_mem);
    @(negedge clk_mem);
    check_done(1'b0);
  endtask

  // back to back reads, each answered MM_RD_LATENCY cycles later
  task automatic read_check();
    host_req_t req;
    for (int n = 0; n < `MM_SIZE + `MM_RD_LATENCY; n++) begin
      req = '0;
      if (n < `MM_SIZE) begin
        req.rd_c = 1'b1;
        req.addr = addr_t'(n);
      end
      @(posedge clk_mem);
      host <= req;
      @(negedge clk_mem);
      if (n >= `MM_RD_LATENCY) begin
        check_row(n - `MM_RD_LATENCY, c_exp[n - `MM_RD_LATENCY], rd_data);
      end
    end
  endtask

  function automatic int clamp_product(input int p);
    if (p > ELEM_MAX) begin
      return ELEM_MAX;
    end else if (p < ELEM_MIN) begin
      return ELEM_MIN;
    end
    return p;
  endfunction

  // C[i][j] is the wrapped sum of clamped A[i][k]*B[k][j]
  task automatic compute_expected();
    int sum;
    int a_el;
    int b_el;
    for (int i = 0; i < `MM_SIZE; i++) begin
      for (int j = 0; j < `MM_SIZE; j++) begin
        sum = 0;
        for (int k = 0; k < `MM_SIZE; k++) begin
          a_el = a_cols[k][i];
          b_el = b_rows[k][j];
          sum  = sum + clamp_product(a_el * b_el);
        end
        c_exp[j][i] = elem_t'(sum);
      end
    end
  endtask

  task automatic run_case();
    load_matrices();
    run_multiply();
    read_check();
  endtask

  initial begin
    reset  = 1'b1;
    start  = 1'b0;
    host   = '0;
    errors = 0;
    checks = 0;
    void'($urandom(RAND_SEED));
    $readmemh("matmul_golden.mem", golden);
    repeat (4) @(posedge clk_mem);
    reset <= 1'b0;
    @(negedge clk_mem);
    check_done(1'b0);
    check_row(0, '0, rd_data);
    // golden cases back to back, no reset between them
    for (int c = 0; c < NUM_CASES; c++) begin
      for (int k = 0; k < `MM_SIZE; k++) begin
        a_cols[k] = golden[c*CASE_WORDS + k];
        b_rows[k] = golden[c*CASE_WORDS + `MM_SIZE + k];
        c_exp[k]  = golden[c*CASE_WORDS + 2*`MM_SIZE + k];
      end
      run_case();
    end
    // random signed operands, full byte range
    for (int r = 0; r < NUM_RANDOM; r++) begin
      for (int k = 0; k < `MM_SIZE; k++) begin
        a_cols[k] = $urandom();
        b_rows[k] = $urandom();
      end
      compute_expected();
      run_case();
    end
    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: matmul_golden.mem
// each case is three lines of four 32-bit hex words
// first A columns 0 to 3, then B rows 0 to 3, then expected C columns 0 to 3
// element 0 sits in the low byte of a word
// case 0 has B as the identity so C equals A
04030201 08070605 fcfdfeff 10807f00
00000001 00000100 00010000 01000000
04030201 08070605 fcfdfeff 10807f00
// case 1 saturates products at 127 and -128 and wraps the sums
40404040 40404040 40404040 40404040
ff000102 0001fdfd 01020201 fe030100
3f3f3f3f 7f7f7f7f 3e3e3e3e 80808080
// case 2 uses small mixed-sign values without saturation
02000301 01fe0002 ff040100 000102ff
ff010002 02000301 000201ff 01fd0200
06fa0504 02000504 0005ff04 00fdff02

// File: sources.f
+incdir+.
mm_data_pkg.sv
mm_ctrl_pkg.sv
matrix_ram.sv
mm_sequencer.sv
mac_pe.sv
systolic_array.sv
result_drain.sv
matmul_top.sv
tb_matmul.sv

// File: Bender.yml
package:
  name: matmul_systolic

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - mm_data_pkg.sv
      - mm_ctrl_pkg.sv
      - matrix_ram.sv
      - mm_sequencer.sv
      - mac_pe.sv
      - systolic_array.sv
      - result_drain.sv
      - matmul_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_matmul.sv
